// File: all.f
+incdir+rtl
rtl/tawas_isa_pkg.sv
rtl/tawas_pipe_pkg.sv
rtl/tawas_fetch.sv
rtl/tawas_regfile.sv
rtl/tawas_au.sv
rtl/tawas_ls.sv
rtl/tawas.sv
tests/tawas_tb.sv

// File: Bender.yml
package:
  name: tawas

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tawas_isa_pkg.sv
      - rtl/tawas_pipe_pkg.sv
      - rtl/tawas_fetch.sv
      - rtl/tawas_regfile.sv
      - rtl/tawas_au.sv
      - rtl/tawas_ls.sv
      - rtl/tawas.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tawas_tb.sv

// File: tests/tawas_tb.sv
// Testbench for tawas; both memories answer one cycle late, thread t stores to words 16*t..16*t+15
`include "tawas_config.svh"

module tawas_tb
  import tawas_isa_pkg::*;
();

  localparam int T0 = 0 * `TAWAS_THREAD_STRIDE;
  localparam int T1 = 1 * `TAWAS_THREAD_STRIDE;
  localparam int T2 = 2 * `TAWAS_THREAD_STRIDE;
  localparam int T3 = 3 * `TAWAS_THREAD_STRIDE;

  // Thread 2 runs its loop five times, which makes it the longest path at 22 instructions
  localparam int LONGEST_PATH = 22;
  localparam int MAX_CYCLES   = 4 * 4 * LONGEST_PATH + 100;

  typedef struct packed {
    logic [7:0]  addr;
    logic [3:0]  op;
    logic [2:0]  rd;
    logic [2:0]  ra;
    logic [2:0]  rb;
    logic [15:0] imm;
  } prog_row_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] value;
  } exp_row_t;

  logic                      clk = 1'b0;
  logic                      reset = 1'b1;
  logic [`TAWAS_PC_W-1:0]    iaddr;
  logic [31:0]               idata = 32'd0;
  logic [31:0]               daddr;
  logic                      dcs;
  logic                      dwr;
  logic [31:0]               dout;
  logic [31:0]               din = 32'd0;
  logic [`TAWAS_THREADS-1:0] halted;

  prog_row_t   prog_tab [$];
  exp_row_t    exp_tab [$];
  bit          written [64];
  logic [31:0] rom [256];
  logic [31:0] ram [64];
  logic [7:0]  iaddr_q = 8'd0;
  logic [31:0] rd_data = 32'd0;
  int          cycles = 0;
  int          errors = 0;
  bit          store_seen = 1'b0;

  tawas i_tawas (
    .clk    (clk),
    .reset  (reset),
    .iaddr  (iaddr),
    .idata  (idata),
    .daddr  (daddr),
    .dcs    (dcs),
    .dwr    (dwr),
    .dout   (dout),
    .din    (din),
    .halted (halted)
  );

  always #10 clk = ~clk;

  task automatic add_instr(input int addr, input tawas_op_e op, input int rd, input int ra,
                           input int rb, input int imm);
    prog_row_t row;
    row.addr = addr[7:0];
    row.op   = op;
    row.rd   = rd[2:0];
    row.ra   = ra[2:0];
    row.rb   = rb[2:0];
    row.imm  = imm[15:0];
    prog_tab.push_back(row);
  endtask

  task automatic add_expect(input logic [31:0] addr, input logic [31:0] value);
    exp_row_t row;
    row.addr  = addr;
    row.value = value;
    exp_tab.push_back(row);
  endtask

  // Stores use r0 as base, which stays zero, so imm is the data address
  task automatic build_tables();
    add_instr(T0 + 0, op_ldi, 1, 0, 0, 16'h1234);
    add_instr(T0 + 1, op_ldi, 2, 0, 0, 16'hFF00);
    add_instr(T0 + 2, op_ldi, 4, 0, 0, 16'h0024);
    add_instr(T0 + 3, op_add, 3, 1, 2, 0);
    add_instr(T0 + 4, op_st, 0, 0, 3, 0);
    add_instr(T0 + 5, op_sub, 3, 1, 2, 0);
    add_instr(T0 + 6, op_st, 0, 0, 3, 1);
    add_instr(T0 + 7, op_and, 3, 1, 2, 0);
    add_instr(T0 + 8, op_st, 0, 0, 3, 2);
    add_instr(T0 + 9, op_or, 3, 1, 2, 0);
    add_instr(T0 + 10, op_st, 0, 0, 3, 3);
    add_instr(T0 + 11, op_xor, 3, 1, 2, 0);
    add_instr(T0 + 12, op_st, 0, 0, 3, 4);
    add_instr(T0 + 13, op_shl, 3, 1, 4, 0);
    add_instr(T0 + 14, op_st, 0, 0, 3, 5);
    add_instr(T0 + 15, op_st, 0, 0, 2, 6);
    add_instr(T0 + 16, op_halt, 0, 0, 0, 0);
    // Store, load back, add, then a store through a pointer with a negative offset
    add_instr(T1 + 0, op_ldi, 1, 0, 0, 16'h5A5A);
    add_instr(T1 + 1, op_ldi, 5, 0, 0, 16'h7001);
    add_instr(T1 + 2, op_st, 0, 0, 1, 16);
    add_instr(T1 + 3, op_ld, 2, 0, 0, 16);
    add_instr(T1 + 4, op_add, 3, 2, 5, 0);
    add_instr(T1 + 5, op_st, 0, 0, 3, 17);
    add_instr(T1 + 6, op_ldi, 6, 0, 0, 20);
    add_instr(T1 + 7, op_st, 0, 6, 2, -2);
    add_instr(T1 + 8, op_halt, 0, 0, 0, 0);
    // Countdown from 5 summing into r2, then a bz that must fall through
    add_instr(T2 + 0, op_ldi, 1, 0, 0, 5);
    add_instr(T2 + 1, op_ldi, 3, 0, 0, 1);
    add_instr(T2 + 2, op_add, 2, 2, 1, 0);
    add_instr(T2 + 3, op_sub, 1, 1, 3, 0);
    add_instr(T2 + 4, op_bnz, 0, 0, 0, -2);
    add_instr(T2 + 5, op_st, 0, 0, 2, 32);
    add_instr(T2 + 6, op_add, 5, 2, 3, 0);
    add_instr(T2 + 7, op_bz, 0, 0, 0, 3);
    add_instr(T2 + 8, op_st, 0, 0, 5, 33);
    add_instr(T2 + 9, op_halt, 0, 0, 0, 0);
    add_instr(T2 + 10, op_st, 0, 0, 5, 34);
    add_instr(T2 + 11, op_halt, 0, 0, 0, 0);
    // Same registers as thread 0 with other values, the and result is zero
    add_instr(T3 + 0, op_ldi, 1, 0, 0, 16'h00F0);
    add_instr(T3 + 1, op_ldi, 2, 0, 0, 16'h0F0F);
    add_instr(T3 + 2, op_ldi, 4, 0, 0, 16'h0003);
    add_instr(T3 + 3, op_add, 3, 1, 2, 0);
    add_instr(T3 + 4, op_st, 0, 0, 3, 48);
    add_instr(T3 + 5, op_and, 3, 1, 2, 0);
    // Thread 2 decodes a sub with a non-zero result just before this bz, so only a
    // per-thread zero flag makes it jump over the halt
    add_instr(T3 + 6, op_bz, 0, 0, 0, 2);
    add_instr(T3 + 7, op_halt, 0, 0, 0, 0);
    add_instr(T3 + 8, op_st, 0, 0, 3, 49);
    add_instr(T3 + 9, op_shl, 3, 1, 4, 0);
    add_instr(T3 + 10, op_st, 0, 0, 3, 50);
    add_instr(T3 + 11, op_halt, 0, 0, 0, 0);

    add_expect(32'd0, 32'h0000_1134);
    add_expect(32'd1, 32'h0000_1334);
    add_expect(32'd2, 32'h0000_1200);
    add_expect(32'd3, 32'hFFFF_FF34);
    add_expect(32'd4, 32'hFFFF_ED34);
    add_expect(32'd5, 32'h0001_2340);
    add_expect(32'd6, 32'hFFFF_FF00);
    add_expect(32'd16, 32'h0000_5A5A);
    add_expect(32'd17, 32'h0000_CA5B);
    add_expect(32'd18, 32'h0000_5A5A);
    add_expect(32'd32, 32'h0000_000F);
    add_expect(32'd33, 32'h0000_0010);
    add_expect(32'd48, 32'h0000_0FFF);
    add_expect(32'd49, 32'h0000_0000);
    add_expect(32'd50, 32'h0000_0780);
  endtask

  task automatic assemble_rom();
    prog_row_t row;
    // Unused words decode as halt and carry their own address in the imm field
    for (int a = 0; a < 256; a++) begin
      rom[a] = {op_halt, 20'h0, 8'(a)};
    end
    for (int i = 0; i < prog_tab.size(); i++) begin
      row = prog_tab[i];
      rom[row.addr] = {row.op, row.rd, row.ra, row.rb, 3'b000, row.imm};
    end
  endtask

  task automatic fill_ram();
    for (int a = 0; a < 64; a++) begin
      ram[a] = $urandom();
    end
  endtask

  task automatic check_idle();
    if (dcs !== 1'b0) begin
      $display("ERROR: dcs = %h before the first store, expected 0", dcs);
      errors++;
    end
    if (dwr !== 1'b0) begin
      $display("ERROR: dwr = %h before the first store, expected 0", dwr);
      errors++;
    end
    if (halted !== '0) begin
      $display("ERROR: halted = %h before the first store, expected 0", halted);
      errors++;
    end
  endtask

  task automatic check_store();
    int row;
    row = -1;
    for (int i = 0; i < exp_tab.size(); i++) begin
      if (exp_tab[i].addr == daddr) begin
        row = i;
      end
    end
    if (halted[daddr[5:4]]) begin
      $display("Data write to address %h after thread %0d had halted", daddr, daddr[5:4]);
      errors++;
    end
    if (row < 0) begin
      $display("Data write to address %h, which no thread should store to", daddr);
      errors++;
    end else begin
      written[row] = 1'b1;
      if (dout !== exp_tab[row].value) begin
        $display("ERROR: dout = %h, expected %h, at daddr = %h", dout, exp_tab[row].value,
                 daddr);
        errors++;
      end
    end
    ram[daddr[5:0]] = dout;
  endtask

  task automatic check_all_written();
    for (int i = 0; i < exp_tab.size(); i++) begin
      if (!written[i]) begin
        $display("No store ever reached data address %h", exp_tab[i].addr);
        errors++;
      end
    end
  endtask

  // Instruction ROM and data RAM, each returning data one cycle after the request
  always @(negedge clk) begin
    cycles  = cycles + 1;
    idata   = rom[iaddr_q];
    if (iaddr[`TAWAS_PC_W-1:8] !== '0) begin
      $display("Instruction address %h lies outside the 256-word ROM", iaddr);
      errors++;
    end
    iaddr_q = iaddr[7:0];
    din     = rd_data;
    if (dcs === 1'b1 && dwr === 1'b1) begin
      check_store();
      store_seen = 1'b1;
    end else begin
      if (!store_seen) begin
        check_idle();
      end
      if (dcs === 1'b1) begin
        rd_data = ram[daddr[5:0]];
      end
    end
  end

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("Timeout after %0d cycles, not every thread reached halt", MAX_CYCLES);
    errors++;
    $display("Errors: %0d", errors);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'he0d3ccdc));
    build_tables();
    assemble_rom();
    fill_ram();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    while (halted !== {`TAWAS_THREADS{1'b1}}) begin
      @(negedge clk);
    end
    // Watch a few more rotations for writes issued after the last halt
    repeat (16) @(negedge clk);
    check_all_written();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: rtl/tawas.sv
// Four-thread barrel core; no bus stalls, both memories must respond exactly one cycle later
`include "tawas_config.svh"

module tawas
  import tawas_isa_pkg::*;
  import tawas_pipe_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,

  output logic [`TAWAS_PC_W-1:0]    iaddr,
  input  logic [31:0]               idata,

  output logic [31:0]               daddr,
  output logic                      dcs,
  output logic                      dwr,
  output logic [31:0]               dout,
  input  logic [31:0]               din,

  output logic [`TAWAS_THREADS-1:0] halted
);

  logic [`TAWAS_THREADS-1:0] au_flags;
  slice_t                    dec_slice;

  logic                      rf_imm_vld;
  reg_sel_t                  rf_imm_sel;
  logic [31:0]               rf_imm;

  logic                      au_op_vld;
  tawas_op_e                 au_op;
  reg_sel_t                  au_rd;
  reg_sel_t                  au_ra;
  reg_sel_t                  au_rb;

  logic                      ls_op_vld;
  ls_kind_e                  ls_kind;
  reg_sel_t                  ls_rd;
  reg_sel_t                  ls_ra;
  reg_sel_t                  ls_rb;
  logic [31:0]               ls_imm;

  tawas_fetch tawas_fetch (
    .clk        (clk),
    .reset      (reset),
    .iaddr      (iaddr),
    .idata      (idata),
    .au_flags   (au_flags),
    .slice      (),
    .halted     (halted),
    .rf_imm_vld (rf_imm_vld),
    .rf_imm_sel (rf_imm_sel),
    .rf_imm     (rf_imm),
    .au_op_vld  (au_op_vld),
    .au_op      (au_op),
    .au_rd      (au_rd),
    .au_ra      (au_ra),
    .au_rb      (au_rb),
    .ls_op_vld  (ls_op_vld),
    .ls_kind    (ls_kind),
    .ls_rd      (ls_rd),
    .ls_ra      (ls_ra),
    .ls_rb      (ls_rb),
    .ls_imm     (ls_imm),
    .dec_slice  (dec_slice)
  );

  reg_sel_t    au_ra_sel;
  logic [31:0] au_ra_data;
  reg_sel_t    au_rb_sel;
  logic [31:0] au_rb_data;
  logic        au_rc_vld;
  slice_t      au_rc_slice;
  reg_sel_t    au_rc_sel;
  logic [31:0] au_rc;

  tawas_au tawas_au (
    .clk         (clk),
    .reset       (reset),
    .dec_slice   (dec_slice),
    .au_op_vld   (au_op_vld),
    .au_op       (au_op),
    .au_rd       (au_rd),
    .au_ra       (au_ra),
    .au_rb       (au_rb),
    .au_ra_sel   (au_ra_sel),
    .au_ra_data  (au_ra_data),
    .au_rb_sel   (au_rb_sel),
    .au_rb_data  (au_rb_data),
    .au_rc_vld   (au_rc_vld),
    .au_rc_slice (au_rc_slice),
    .au_rc_sel   (au_rc_sel),
    .au_rc       (au_rc),
    .au_flags    (au_flags)
  );

  reg_sel_t    ls_ptr_sel;
  logic [31:0] ls_ptr;
  reg_sel_t    ls_store_sel;
  logic [31:0] ls_store;
  logic        ls_load_vld;
  slice_t      ls_load_slice;
  reg_sel_t    ls_load_sel;
  logic [31:0] ls_load;

  tawas_ls tawas_ls (
    .clk           (clk),
    .reset         (reset),
    .dec_slice     (dec_slice),
    .ls_op_vld     (ls_op_vld),
    .ls_kind       (ls_kind),
    .ls_rd         (ls_rd),
    .ls_ra         (ls_ra),
    .ls_rb         (ls_rb),
    .ls_imm        (ls_imm),
    .ls_ptr_sel    (ls_ptr_sel),
    .ls_ptr        (ls_ptr),
    .ls_store_sel  (ls_store_sel),
    .ls_store      (ls_store),
    .daddr         (daddr),
    .dcs           (dcs),
    .dwr           (dwr),
    .dout          (dout),
    .din           (din),
    .ls_load_vld   (ls_load_vld),
    .ls_load_slice (ls_load_slice),
    .ls_load_sel   (ls_load_sel),
    .ls_load       (ls_load)
  );

  tawas_regfile tawas_regfile (
    .clk           (clk),
    .reset         (reset),
    .dec_slice     (dec_slice),
    .rf_imm_vld    (rf_imm_vld),
    .rf_imm_sel    (rf_imm_sel),
    .rf_imm        (rf_imm),
    .au_ra_sel     (au_ra_sel),
    .au_ra_data    (au_ra_data),
    .au_rb_sel     (au_rb_sel),
    .au_rb_data    (au_rb_data),
    .au_rc_vld     (au_rc_vld),
    .au_rc_slice   (au_rc_slice),
    .au_rc_sel     (au_rc_sel),
    .au_rc         (au_rc),
    .ls_ptr_sel    (ls_ptr_sel),
    .ls_ptr        (ls_ptr),
    .ls_store_sel  (ls_store_sel),
    .ls_store      (ls_store),
    .ls_load_vld   (ls_load_vld),
    .ls_load_slice (ls_load_slice),
    .ls_load_sel   (ls_load_sel),
    .ls_load       (ls_load)
  );

endmodule

// File: rtl/tawas_ls.sv
// Load/store unit; full-word accesses only, the data port must answer in exactly one cycle
module tawas_ls
  import tawas_isa_pkg::*;
  import tawas_pipe_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  input  slice_t      dec_slice,
  input  logic        ls_op_vld,
  input  ls_kind_e    ls_kind,
  input  reg_sel_t    ls_rd,
  input  reg_sel_t    ls_ra,
  input  reg_sel_t    ls_rb,
  input  logic [31:0] ls_imm,

  output reg_sel_t    ls_ptr_sel,
  input  logic [31:0] ls_ptr,
  output reg_sel_t    ls_store_sel,
  input  logic [31:0] ls_store,

  output logic [31:0] daddr,
  output logic        dcs,
  output logic        dwr,
  output logic [31:0] dout,
  input  logic [31:0] din,

  output logic        ls_load_vld,
  output slice_t      ls_load_slice,
  output reg_sel_t    ls_load_sel,
  output logic [31:0] ls_load
);

  logic     is_store;
  slice_t   req_slice;
  reg_sel_t req_sel;

  // Base register is ra, store data comes from rb
  assign ls_ptr_sel   = ls_ra;
  assign ls_store_sel = ls_rb;
  assign is_store     = (ls_kind == tawas_pipe_pkg::ls_store);

  // Load data goes straight from the port into the register file
  assign ls_load = din;

  always_ff @(posedge clk) begin
    if (reset) begin
      dcs         <= 1'b0;
      dwr         <= 1'b0;
      ls_load_vld <= 1'b0;
    end else begin
      dcs         <= ls_op_vld;
      dwr         <= ls_op_vld && is_store;
      ls_load_vld <= dcs && !dwr;
    end
  end

  // Request payload, then the load destination is held one more cycle for din
  always_ff @(posedge clk) begin
    daddr         <= ls_ptr + ls_imm;
    dout          <= ls_store;
    req_slice     <= dec_slice;
    req_sel       <= ls_rd;
    ls_load_slice <= req_slice;
    ls_load_sel   <= req_sel;
  end

endmodule

// File: rtl/tawas_au.sv
// Arithmetic unit; results and zero flags land one cycle after decode, shl uses rb[4:0] only
`include "tawas_config.svh"

module tawas_au
  import tawas_isa_pkg::*;
  import tawas_pipe_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,

  input  slice_t                    dec_slice,
  input  logic                      au_op_vld,
  input  tawas_op_e                 au_op,
  input  reg_sel_t                  au_rd,
  input  reg_sel_t                  au_ra,
  input  reg_sel_t                  au_rb,

  output reg_sel_t                  au_ra_sel,
  input  logic [31:0]               au_ra_data,
  output reg_sel_t                  au_rb_sel,
  input  logic [31:0]               au_rb_data,

  output logic                      au_rc_vld,
  output slice_t                    au_rc_slice,
  output reg_sel_t                  au_rc_sel,
  output logic [31:0]               au_rc,

  output logic [`TAWAS_THREADS-1:0] au_flags
);

  logic [31:0] result;

  assign au_ra_sel = au_ra;
  assign au_rb_sel = au_rb;

  always_comb begin
    case (au_op)
      op_add:  result = au_ra_data + au_rb_data;
      op_sub:  result = au_ra_data - au_rb_data;
      op_and:  result = au_ra_data & au_rb_data;
      op_or:   result = au_ra_data | au_rb_data;
      op_xor:  result = au_ra_data ^ au_rb_data;
      op_shl:  result = au_ra_data << au_rb_data[4:0];
      default: result = '0;
    endcase
  end

  // Zero flag of the issuing thread changes in the same cycle as the write-back
  always_ff @(posedge clk) begin
    if (reset) begin
      au_rc_vld <= 1'b0;
      au_flags  <= '0;
    end else begin
      au_rc_vld <= au_op_vld;
      if (au_op_vld) begin
        au_flags[dec_slice] <= (result == 32'd0);
      end
    end
  end

  always_ff @(posedge clk) begin
    au_rc_slice <= dec_slice;
    au_rc_sel   <= au_rd;
    au_rc       <= result;
  end

endmodule

// File: rtl/tawas_regfile.sv
// Per-thread register banks; write ports are assumed never to hit the same thread in one cycle
`include "tawas_config.svh"

module tawas_regfile
  import tawas_isa_pkg::*;
  import tawas_pipe_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  input  slice_t      dec_slice,

  input  logic        rf_imm_vld,
  input  reg_sel_t    rf_imm_sel,
  input  logic [31:0] rf_imm,

  input  reg_sel_t    au_ra_sel,
  output logic [31:0] au_ra_data,
  input  reg_sel_t    au_rb_sel,
  output logic [31:0] au_rb_data,

  input  logic        au_rc_vld,
  input  slice_t      au_rc_slice,
  input  reg_sel_t    au_rc_sel,
  input  logic [31:0] au_rc,

  input  reg_sel_t    ls_ptr_sel,
  output logic [31:0] ls_ptr,
  input  reg_sel_t    ls_store_sel,
  output logic [31:0] ls_store,

  input  logic        ls_load_vld,
  input  slice_t      ls_load_slice,
  input  reg_sel_t    ls_load_sel,
  input  logic [31:0] ls_load
);

  logic [31:0] regs [`TAWAS_THREADS][`TAWAS_REGS];

  // Reads always come from the thread being decoded
  assign au_ra_data = regs[dec_slice][au_ra_sel];
  assign au_rb_data = regs[dec_slice][au_rb_sel];
  assign ls_ptr     = regs[dec_slice][ls_ptr_sel];
  assign ls_store   = regs[dec_slice][ls_store_sel];

  // Immediates belong to the decode thread, later results carry their own thread tag
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int t = 0; t < `TAWAS_THREADS; t++) begin
        for (int r = 0; r < `TAWAS_REGS; r++) begin
          regs[t][r] <= '0;
        end
      end
    end else begin
      if (rf_imm_vld) begin
        regs[dec_slice][rf_imm_sel] <= rf_imm;
      end
      if (au_rc_vld) begin
        regs[au_rc_slice][au_rc_sel] <= au_rc;
      end
      if (ls_load_vld) begin
        regs[ls_load_slice][ls_load_sel] <= ls_load;
      end
    end
  end

endmodule

// File: rtl/tawas_fetch.sv
// Fetch and decode; the instruction port must return data exactly one cycle after iaddr
`include "tawas_config.svh"

module tawas_fetch
  import tawas_isa_pkg::*;
  import tawas_pipe_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,

  output logic [`TAWAS_PC_W-1:0]    iaddr,
  input  logic [31:0]               idata,

  input  logic [`TAWAS_THREADS-1:0] au_flags,
  output slice_t                    slice,
  output logic [`TAWAS_THREADS-1:0] halted,

  output logic                      rf_imm_vld,
  output reg_sel_t                  rf_imm_sel,
  output logic [31:0]               rf_imm,

  output logic                      au_op_vld,
  output tawas_op_e                 au_op,
  output reg_sel_t                  au_rd,
  output reg_sel_t                  au_ra,
  output reg_sel_t                  au_rb,

  output logic                      ls_op_vld,
  output ls_kind_e                  ls_kind,
  output reg_sel_t                  ls_rd,
  output reg_sel_t                  ls_ra,
  output reg_sel_t                  ls_rb,
  output logic [31:0]               ls_imm,

  output slice_t                    dec_slice
);

  logic [`TAWAS_PC_W-1:0] pc [`TAWAS_THREADS];
  logic                   dec_vld;
  tawas_instr_t           instr;
  imm_t                   imm;
  logic [31:0]            imm_sext;
  logic [`TAWAS_PC_W-1:0] dec_pc;
  logic                   dec_zero;
  logic                   br_taken;
  logic                   dec_halt;

  // The slice in flight picks which thread's PC goes out this cycle
  assign iaddr = pc[slice];

  // Everything below decodes the word fetched for the previous slice
  assign instr    = idata;
  assign imm      = instr.imm;
  assign imm_sext = {{16{imm[15]}}, imm};
  assign dec_pc   = pc[dec_slice];
  assign dec_zero = au_flags[dec_slice];

  assign br_taken = dec_vld && (((instr.op == op_bz) && dec_zero) ||
                                ((instr.op == op_bnz) && !dec_zero));
  assign dec_halt = dec_vld && (instr.op == op_halt);

  assign rf_imm_vld = dec_vld && (instr.op == op_ldi);
  assign rf_imm_sel = instr.rd;
  assign rf_imm     = imm_sext;

  assign au_op_vld = dec_vld && (instr.op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl});
  assign au_op     = instr.op;
  assign au_rd     = instr.rd;
  assign au_ra     = instr.ra;
  assign au_rb     = instr.rb;

  assign ls_op_vld = dec_vld && ((instr.op == op_ld) || (instr.op == op_st));
  assign ls_kind   = (instr.op == op_st) ? ls_store : ls_load;
  assign ls_rd     = instr.rd;
  assign ls_ra     = instr.ra;
  assign ls_rb     = instr.rb;
  assign ls_imm    = imm_sext;

  always_ff @(posedge clk) begin
    if (reset) begin
      slice     <= '0;
      dec_slice <= '0;
      dec_vld   <= 1'b0;
      halted    <= '0;
      for (int t = 0; t < `TAWAS_THREADS; t++) begin
        pc[t] <= `TAWAS_PC_W'(t * `TAWAS_THREAD_STRIDE);
      end
    end else begin
      slice     <= slice_t'(slice + 1'b1);
      dec_slice <= slice;
      // A halted thread keeps its slot but issues nothing
      dec_vld   <= !halted[slice];
      if (dec_halt) begin
        halted[dec_slice] <= 1'b1;
      end else if (br_taken) begin
        pc[dec_slice] <= dec_pc + imm_sext[`TAWAS_PC_W-1:0];
      end else if (dec_vld) begin
        pc[dec_slice] <= dec_pc + 1'b1;
      end
    end
  end

endmodule

// File: rtl/tawas_pipe_pkg.sv
// Pipeline-side types; the slice index width must match the thread count of four
package tawas_pipe_pkg;

  // Thread index, which is also the pipeline slice number
  typedef logic [1:0] slice_t;

  // Kind of data memory access issued by the load/store unit
  typedef enum logic {
    ls_load  = 1'b0,
    ls_store = 1'b1
  } ls_kind_e;

endpackage

// File: rtl/tawas_isa_pkg.sv
// Instruction set types; opcodes 13 to 15 are unassigned and execute as nop
package tawas_isa_pkg;

  // Opcode in bits 31:28 of the instruction word
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_ldi  = 4'd1,
    op_add  = 4'd2,
    op_sub  = 4'd3,
    op_and  = 4'd4,
    op_or   = 4'd5,
    op_xor  = 4'd6,
    op_shl  = 4'd7,
    op_ld   = 4'd8,
    op_st   = 4'd9,
    op_bz   = 4'd10,
    op_bnz  = 4'd11,
    op_halt = 4'd12
  } tawas_op_e;

  // Register number within one thread's bank
  typedef logic [2:0] reg_sel_t;

  // Signed immediate, extended to 32 bits before use
  typedef logic [15:0] imm_t;

  // Instruction word layout
  //   31:28 opcode
  //   27:25 rd
  //   24:22 ra
  //   21:19 rb
  //   18:16 unused
  //   15:0  imm
  typedef struct packed {
    tawas_op_e  op;
    reg_sel_t   rd;
    reg_sel_t   ra;
    reg_sel_t   rb;
    logic [2:0] rsvd;
    imm_t       imm;
  } tawas_instr_t;

endpackage

// File: rtl/tawas_config.svh
// Core sizing; the RTL assumes four threads with eight registers each and a 2-bit slice index
`ifndef TAWAS_CONFIG_SVH
`define TAWAS_CONFIG_SVH

// Number of hardware threads, one per pipeline slice
`define TAWAS_THREADS 4

// General purpose registers per thread
`define TAWAS_REGS 8

// Instruction address width, counted in 32-bit words
`define TAWAS_PC_W 24

// Each thread starts at its own block of instruction words
// Thread t comes out of reset at t * TAWAS_THREAD_STRIDE
`define TAWAS_THREAD_STRIDE 64

`endif
